//--- common/bp_settings.svh
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// Instructions per fetch block, each one 32-bit word
`define BP_IF_WIDTH         2

// Micro BTB, one table each for branches and jumps
`define BP_UBTB_DEPTH       4
`define BP_UBTB_IDX_BITS    2

// Tag comes from pc[11:2]
`define BP_UBTB_TAG_BITS    10

// Pattern history table of 64 two-bit counters
`define BP_PHT_IDX_BITS     6

// History is as long as the counter index so they XOR bit for bit
`define BP_GHR_BITS         `BP_PHT_IDX_BITS

`endif

//--- common/bp_pkg.sv
`default_nettype none

`include "bp_settings.svh"

package bp_pkg;

    // Instruction address or branch target
    typedef logic [31:0] addr_t;

    // Micro BTB tag and table index
    typedef logic [`BP_UBTB_TAG_BITS-1:0] ubtb_tag_t;
    typedef logic [`BP_UBTB_IDX_BITS-1:0] ubtb_idx_t;

    // Counter index and global history
    typedef logic [`BP_PHT_IDX_BITS-1:0] pht_idx_t;
    typedef logic [`BP_GHR_BITS-1:0]     ghr_t;

    // One bit per fetch slot, bit 0 is the instruction at the block address
    typedef logic [`BP_IF_WIDTH-1:0] slot_mask_t;

endpackage

`default_nettype wire

//--- gshare/gshare.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module gshare (
    input  logic                clk,
    input  logic                rst,

    input  bp_pkg::addr_t       blk_pc,
    output bp_pkg::slot_mask_t  gshare_taken,

    input  logic                update_en,
    input  bp_pkg::addr_t       update_pc,
    input  logic                update_taken,
    input  logic                update_is_jump
);
    import bp_pkg::*;

    localparam int PHT_DEPTH = 1 << `BP_PHT_IDX_BITS;

    // Two-bit saturating counter, upper bit is the taken vote
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_MIN     = 2'b00;
    localparam ctr_t CTR_WEAK_NT = 2'b01;
    localparam ctr_t CTR_MAX     = 2'b11;

    ctr_t                           pht [PHT_DEPTH];
    ghr_t                           ghr;
    pht_idx_t                       upd_idx;
    pht_idx_t [`BP_IF_WIDTH-1:0]    slot_idx;
    logic                           train_en;

    for (genvar w = 0; w < `BP_IF_WIDTH; w++) begin : g_slot
        addr_t slot_pc;

        assign slot_pc         = blk_pc + addr_t'(4 * w);
        assign slot_idx[w]     = slot_pc[`BP_PHT_IDX_BITS+1:2] ^ pht_idx_t'(ghr);
        assign gshare_taken[w] = pht[slot_idx[w]][1];
    end

    // Jumps are always taken and carry no direction information
    assign train_en = update_en && !update_is_jump;

    // Hashed with the history as it stands before this update shifts in
    assign upd_idx = update_pc[`BP_PHT_IDX_BITS+1:2] ^ pht_idx_t'(ghr);

    always_ff @(posedge clk) begin
        if (rst) begin
            ghr <= '0;
            for (int i = 0; i < PHT_DEPTH; i++) begin
                pht[i] <= CTR_WEAK_NT;
            end
        end else if (train_en) begin
            ghr <= {ghr[`BP_GHR_BITS-2:0], update_taken};
            if (update_taken) begin
                if (pht[upd_idx] != CTR_MAX) begin
                    pht[upd_idx] <= pht[upd_idx] + 1'b1;
                end
            end else if (pht[upd_idx] != CTR_MIN) begin
                pht[upd_idx] <= pht[upd_idx] - 1'b1;
            end
        end
    end

    // Votes must be clean once counters are initialized and fetch is running
    a_taken_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(gshare_taken))
        else $error("gshare vote carries unknown bits");

    a_update_aligned: assert property (@(posedge clk) disable iff (rst)
        update_en |-> update_pc[1:0] == 2'b00)
        else $error("commit update pc is not word aligned");

endmodule

`default_nettype wire

//--- ubtb/ubtb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module ubtb (
    input  logic                                clk,
    input  logic                                rst,

    input  bp_pkg::addr_t                       blk_pc,
    input  bp_pkg::slot_mask_t                  gshare_taken,
    output bp_pkg::slot_mask_t                  predict_taken,
    output bp_pkg::addr_t [`BP_IF_WIDTH-1:0]    predict_target,

    input  logic                                update_en,
    input  bp_pkg::addr_t                       update_pc,
    input  bp_pkg::addr_t                       update_target,
    input  logic                                update_taken,
    input  logic                                update_is_jump
);
    import bp_pkg::*;

    localparam int        T_BR     = 0;
    localparam int        T_JMP    = 1;
    localparam ubtb_idx_t LAST_IDX = ubtb_idx_t'(`BP_UBTB_DEPTH - 1);

    typedef struct packed {
        logic       valid;
        ubtb_tag_t  tag;
        addr_t      target;
    } entry_t;

    typedef enum logic [2:0] {
        KIND_FILL       = 3'b001,
        KIND_REFRESH    = 3'b010,
        KIND_OVERWRITE  = 3'b100
    } upd_kind_t;

    addr_t      [`BP_IF_WIDTH-1:0]  slot_pc;
    ubtb_tag_t  [`BP_IF_WIDTH-1:0]  slot_tag;
    ubtb_tag_t                      upd_tag;

    // Hit results per table, indexed by T_BR and T_JMP
    slot_mask_t                     tbl_hit    [2];
    addr_t      [`BP_IF_WIDTH-1:0]  tbl_target [2];

    assign upd_tag = update_pc[`BP_UBTB_TAG_BITS+1:2];

    for (genvar w = 0; w < `BP_IF_WIDTH; w++) begin : g_slot
        assign slot_pc[w]  = blk_pc + addr_t'(4 * w);
        assign slot_tag[w] = slot_pc[w][`BP_UBTB_TAG_BITS+1:2];
    end

    // Branch table and jump table share all of their logic
    for (genvar t = 0; t < 2; t++) begin : g_tbl
        entry_t                         entries [`BP_UBTB_DEPTH];
        ubtb_idx_t                      head;
        upd_kind_t                      kind;
        ubtb_idx_t                      hit_idx;
        ubtb_idx_t                      free_idx;
        ubtb_idx_t                      wr_idx;
        logic                           tag_hit;
        logic                           has_free;
        logic                           wr_en;
        slot_mask_t                     hit;
        addr_t  [`BP_IF_WIDTH-1:0]      hit_target;

        // Only taken outcomes are stored
        assign wr_en = update_en && update_taken &&
                       ((t == T_JMP) ? update_is_jump : !update_is_jump);

        always_comb begin
            tag_hit  = 1'b0;
            hit_idx  = '0;
            has_free = 1'b0;
            free_idx = '0;
            for (int i = `BP_UBTB_DEPTH - 1; i >= 0; i--) begin
                if (entries[i].valid && entries[i].tag == upd_tag) begin
                    tag_hit = 1'b1;
                    hit_idx = ubtb_idx_t'(i);
                end
                if (!entries[i].valid) begin
                    has_free = 1'b1;
                    free_idx = ubtb_idx_t'(i); // Downward scan ends on the lowest free entry
                end
            end

            // A matching tag wins over a free slot, so tags stay unique
            if (tag_hit) begin
                kind   = KIND_REFRESH;
                wr_idx = hit_idx;
            end else if (has_free) begin
                kind   = KIND_FILL;
                wr_idx = free_idx;
            end else begin
                kind   = KIND_OVERWRITE;
                wr_idx = head;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                head <= '0;
                for (int i = 0; i < `BP_UBTB_DEPTH; i++) begin
                    entries[i].valid <= 1'b0;
                end
            end else if (wr_en) begin
                entries[wr_idx].valid  <= 1'b1;
                entries[wr_idx].tag    <= upd_tag;
                entries[wr_idx].target <= update_target;
                if (kind == KIND_OVERWRITE) begin
                    head <= (head == LAST_IDX) ? '0 : head + 1'b1; // Oldest entry goes first
                end
            end
        end

        always_comb begin
            hit        = '0;
            hit_target = '0;
            for (int w = 0; w < `BP_IF_WIDTH; w++) begin
                for (int i = 0; i < `BP_UBTB_DEPTH; i++) begin
                    if (entries[i].valid && entries[i].tag == slot_tag[w]) begin
                        hit[w]        = 1'b1;
                        hit_target[w] = entries[i].target;
                    end
                end
            end
        end

        assign tbl_hit[t]    = hit;
        assign tbl_target[t] = hit_target;

        // The chosen kind has to match the entry that it rewrites
        a_kind_onehot: assert property (@(posedge clk) disable iff (rst)
            update_en |-> $onehot(kind) &&
                ((kind == KIND_REFRESH) ==
                 (entries[wr_idx].valid && entries[wr_idx].tag == upd_tag)) &&
                ((kind == KIND_FILL) == !entries[wr_idx].valid))
            else $error("ubtb table %0d update kind does not match the written entry", t);

        for (genvar i = 0; i < `BP_UBTB_DEPTH; i++) begin : g_pair_i
            for (genvar j = i + 1; j < `BP_UBTB_DEPTH; j++) begin : g_pair_j
                a_unique_tag: assert property (@(posedge clk) disable iff (rst)
                    !(entries[i].valid && entries[j].valid &&
                      entries[i].tag == entries[j].tag))
                    else $error("ubtb table %0d holds tag twice in %0d and %0d", t, i, j);
            end
        end
    end

    // A jump hit beats a branch hit in the same slot
    always_comb begin
        for (int w = 0; w < `BP_IF_WIDTH; w++) begin
            if (tbl_hit[T_JMP][w]) begin
                predict_taken[w]  = 1'b1;
                predict_target[w] = tbl_target[T_JMP][w];
            end else if (tbl_hit[T_BR][w] && gshare_taken[w]) begin
                predict_taken[w]  = 1'b1;
                predict_target[w] = tbl_target[T_BR][w];
            end else begin
                predict_taken[w]  = 1'b0;
                predict_target[w] = slot_pc[w] + addr_t'(4);
            end
        end
    end

endmodule

`default_nettype wire

//--- design/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module branch_predictor (
    input  logic                                clk,
    input  logic                                rst,

    // Fetch side
    input  bp_pkg::addr_t                       blk_pc,
    output bp_pkg::slot_mask_t                  predict_taken,
    output bp_pkg::addr_t [`BP_IF_WIDTH-1:0]    predict_target,

    // Commit side, one-cycle strobe per resolved control transfer
    input  logic                                update_en,
    input  bp_pkg::addr_t                       update_pc,
    input  bp_pkg::addr_t                       update_target,
    input  logic                                update_taken,
    input  logic                                update_is_jump
);
    import bp_pkg::*;

    slot_mask_t gshare_taken; // Direction votes, used by ubtb for branch hits only

    gshare u_gshare (
        .clk            (clk),
        .rst            (rst),
        .blk_pc         (blk_pc),
        .gshare_taken   (gshare_taken),
        .update_en      (update_en),
        .update_pc      (update_pc),
        .update_taken   (update_taken),
        .update_is_jump (update_is_jump)
    );

    // Target lookup and final taken decision per slot
    ubtb u_ubtb (
        .clk            (clk),
        .rst            (rst),
        .blk_pc         (blk_pc),
        .gshare_taken   (gshare_taken),
        .predict_taken  (predict_taken),
        .predict_target (predict_target),
        .update_en      (update_en),
        .update_pc      (update_pc),
        .update_target  (update_target),
        .update_taken   (update_taken),
        .update_is_jump (update_is_jump)
    );

endmodule

`default_nettype wire

//--- dv/tb_branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int REC_WORDS   = 6; // op, test, pc, target or slot 0, flags or mask, slot 1
    localparam int MAX_RECORDS = 64;
    localparam int RESET_LIMIT = 40;
    localparam int RUN_LIMIT   = 1000;

    localparam logic [31:0] OP_UPDATE = 32'h1;
    localparam logic [31:0] OP_LOOKUP = 32'h2;
    localparam logic [31:0] OP_END    = 32'hf;

    logic                       clk;
    logic                       rst;
    addr_t                      blk_pc;
    slot_mask_t                 predict_taken;
    addr_t [`BP_IF_WIDTH-1:0]   predict_target;
    logic                       update_en;
    addr_t                      update_pc;
    addr_t                      update_target;
    logic                       update_taken;
    logic                       update_is_jump;

    logic [31:0]                patterns [REC_WORDS*MAX_RECORDS];
    int                         run_cycles;
    int                         checks_done;

    branch_predictor dut (
        .clk            (clk),
        .rst            (rst),
        .blk_pc         (blk_pc),
        .predict_taken  (predict_taken),
        .predict_target (predict_target),
        .update_en      (update_en),
        .update_pc      (update_pc),
        .update_target  (update_target),
        .update_taken   (update_taken),
        .update_is_jump (update_is_jump)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (rst) begin
            run_cycles <= 0;
        end else begin
            run_cycles <= run_cycles + 1;
        end
    end

    function automatic string test_name(input int test_id);
        case (test_id)
            1:       return "reset_state";
            2:       return "jump_hit";
            3:       return "branch_training";
            4:       return "jump_over_branch";
            5:       return "fifo_replace";
            6:       return "back_to_back";
            default: return "unknown_test";
        endcase
    endfunction

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        abort_run();
    endtask

    // Commit strobe lasts until the next record drives the inputs again
    task automatic drive_update(input addr_t pc, input addr_t target, input logic [31:0] flags);
        @(posedge clk);
        #1;
        update_en      = 1'b1;
        update_pc      = pc;
        update_target  = target;
        update_taken   = flags[0];
        update_is_jump = flags[1];
    endtask

    task automatic drive_lookup(input addr_t pc);
        @(posedge clk);
        #1;
        update_en = 1'b0;
        blk_pc    = pc;
    endtask

    task automatic check_lookup(input int test_id, input slot_mask_t exp_mask,
                                input addr_t exp_t0, input addr_t exp_t1);
        addr_t exp_target [2];

        exp_target[0] = exp_t0;
        exp_target[1] = exp_t1;
        assert (predict_taken === exp_mask)
        else begin
            $display("Fail %s: blk_pc %h taken mask expected %b actual %b",
                     test_name(test_id), blk_pc, exp_mask, predict_taken);
            abort_run();
        end
        for (int w = 0; w < 2; w++) begin
            assert (predict_target[w] === exp_target[w])
            else begin
                $display("Fail %s: blk_pc %h slot %0d target expected %h actual %h",
                         test_name(test_id), blk_pc, w, exp_target[w], predict_target[w]);
                abort_run();
            end
        end
        checks_done++;
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        blk_pc         = '0;
        update_en      = 1'b0;
        update_pc      = '0;
        update_target  = '0;
        update_taken   = 1'b0;
        update_is_jump = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
    end

    initial begin
        int          rec;
        int          base;
        int          test_id;
        int          wait_cycles;
        logic        done;
        logic [31:0] op;

        checks_done = 0;
        $readmemh("dv/bp_patterns.txt", patterns);
        if (`BP_IF_WIDTH != 2) begin
            report_failure("the pattern file holds targets for exactly two slots");
        end

        wait_cycles = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > RESET_LIMIT) begin
                report_failure("reset was still asserted after 40 cycles");
            end
        end

        rec  = 0;
        done = 1'b0;
        while (!done) begin
            if (rec >= MAX_RECORDS) begin
                report_failure("the pattern file ran out without an end record");
            end
            if (run_cycles > RUN_LIMIT) begin
                report_failure("pattern replay did not reach the end record in time");
            end
            base    = rec * REC_WORDS;
            op      = patterns[base];
            test_id = int'(patterns[base+1]);
            if (op === OP_UPDATE) begin
                drive_update(patterns[base+2], patterns[base+3], patterns[base+4]);
            end else if (op === OP_LOOKUP) begin
                drive_lookup(patterns[base+2]);
                @(posedge clk);
                @(negedge clk); // State only moves on an update, so the lookup is settled here
                check_lookup(test_id, slot_mask_t'(patterns[base+4]),
                             patterns[base+3], patterns[base+5]);
            end else if (op === OP_END) begin
                done = 1'b1;
            end else begin
                report_failure($sformatf("record %0d has an unknown opcode %h", rec, op));
            end
            rec++;
        end

        @(posedge clk);
        #1;
        update_en = 1'b0;
        @(posedge clk);
        if (checks_done == 0) begin
            report_failure("no lookup was checked");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- dv/bp_patterns.txt
// op test pc target/exp_slot0 flags/exp_mask exp_slot1
// op 1 update (flags bit1 is_jump, bit0 taken), op 2 lookup, op f end
// Empty tables after reset
2 1 00000100 00000104 0 00000108
2 1 00000110 00000114 0 00000118
// Taken jumps hit in slot 0 and slot 1
1 2 00000110 00000400 3 00000000
2 2 00000110 00000400 1 00000118
1 2 00000124 00000480 3 00000000
2 2 00000120 00000124 2 00000480
// A not-taken jump is not stored
1 2 00000130 00000500 2 00000000
2 2 00000130 00000134 0 00000138
2 2 00000110 00000400 1 00000118
// Branch 0x150, each update moves the history onto a fresh counter
1 3 00000150 00000700 1 00000000
2 3 00000150 00000154 0 00000158
1 3 00000150 00000700 1 00000000
1 3 00000150 00000700 1 00000000
1 3 00000150 00000700 1 00000000
1 3 00000150 00000700 1 00000000
1 3 00000150 00000700 1 00000000
// History is all ones, counter 43 still weakly not-taken
2 3 00000150 00000154 0 00000158
1 3 00000150 00000700 1 00000000
2 3 00000150 00000700 1 00000158
// Same pc as a jump with another target
1 4 00000150 00000780 3 00000000
2 4 00000150 00000780 1 00000158
// Fourth jump fills, refresh of 0x124, fifth replaces 0x110
1 5 00000160 00000800 3 00000000
1 5 00000124 00000880 3 00000000
1 5 00000170 00000900 3 00000000
2 5 00000110 00000114 0 00000118
2 5 00000120 00000124 2 00000880
2 5 00000170 00000900 1 00000178
// Sixth replaces 0x124
1 5 00000180 00000980 3 00000000
2 5 00000120 00000124 0 00000128
2 5 00000180 00000980 1 00000188
2 5 00000160 00000800 1 00000168
2 5 00000150 00000780 1 00000158
// Three updates on consecutive cycles
1 6 00000190 00000a00 3 00000000
1 6 000001a4 00000a80 3 00000000
1 6 000001b0 00000b00 1 00000000
2 6 000001b0 00000b00 1 000001b8
2 6 00000190 00000a00 1 00000198
2 6 000001a0 000001a4 2 00000a80
// Jump 0x150 is gone, its branch entry now shows
2 6 00000150 00000700 1 00000158
2 6 00000160 00000164 0 00000168
f 0 00000000 00000000 0 00000000

//--- tb.f
+incdir+common
common/bp_pkg.sv
gshare/gshare.sv
ubtb/ubtb.sv
design/branch_predictor.sv
dv/tb_branch_predictor.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_branch_predictor
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module "$TOP" -f tb.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/V"$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$SIM_LOG"; then
    exit 0
fi
echo "Pass message not found in $SIM_LOG"
exit 1
